// File: Bender.yml
package:
  name: mpsoc_tile

sources:
  - design/mpsoc_tile_pkg.sv
  - design/na_ctrl.sv
  - design/na_hdr_decode.sv
  - design/na_regfile.sv
  - design/na_reply_gen.sv
  - design/mpsoc_tile_top.sv
  - target: test
    files:
      - testbench/mpsoc_tile_assertions.sv
      - testbench/mpsoc_tile_tb.sv

// File: design/mpsoc_tile_pkg.sv
//////////////////////////////////////////////////////////////////////
// Tile network adapter package
// Flit, header and trace types plus command codes shared by the
// message-passing endpoint of one compute tile
//////////////////////////////////////////////////////////////////////

package mpsoc_tile_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // NoC flit payload width
  localparam int FLIT_W = 32;
  // Tile address width, as used by dest and src
  localparam int TILE_W = 5;
  // Register index width in the header
  localparam int REG_IDX_W = 4;
  // Packet class field width
  localparam int CLASS_W = 3;
  // Unused tail of the header word
  localparam int RSVD_W = FLIT_W - 2 * TILE_W - CLASS_W - 2 - REG_IDX_W;

  // Class used by the simple message-passing endpoint
  localparam logic [CLASS_W-1:0] PKT_CLASS_MP = 3'd0;

  //////////////////////////////////////////////////////////////////////
  // Command codes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CMD_WRITE = 2'd0,
    CMD_READ  = 2'd1,
    CMD_REPLY = 2'd2,
    // Reserved, never serviced
    CMD_RSVD  = 2'd3
  } na_cmd_e;

  //////////////////////////////////////////////////////////////////////
  // Flit and header types
  //////////////////////////////////////////////////////////////////////

  // One flit on the link, data word plus end-of-packet marker
  typedef struct packed {
    logic [FLIT_W-1:0] data;
    logic              last;
  } noc_flit_t;

  // Header fields, MSB first
  typedef struct packed {
    logic [TILE_W-1:0]    dest;
    logic [CLASS_W-1:0]   pkt_class;
    logic [TILE_W-1:0]    src;
    na_cmd_e              cmd;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [RSVD_W-1:0]    rsvd;
  } noc_hdr_t;

  // A header word, seen either raw or split into fields
  typedef union packed {
    logic [FLIT_W-1:0] raw;
    noc_hdr_t          hdr;
  } noc_flit_u;

  //////////////////////////////////////////////////////////////////////
  // Writeback trace
  //////////////////////////////////////////////////////////////////////

  // One record per register write, for the testbench monitor
  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] wbreg;
    logic [FLIT_W-1:0]    wbdata;
  } trace_t;

endpackage

// File: design/mpsoc_tile_top.sv
//////////////////////////////////////////////////////////////////////
// Message-passing tile endpoint
// Joins controller, header decoder, register bank and reply generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mpsoc_tile_top import mpsoc_tile_pkg::*; #(
  parameter logic [TILE_W-1:0] TILE_ID  = '0,
  parameter int unsigned       NUM_REGS = 16
) (
  input  logic      clk,
  input  logic      rst_n_i,
  // NoC input port
  input  noc_flit_t in_flit_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // NoC output port
  output noc_flit_t out_flit_o,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  // Writeback trace
  output trace_t    trace_o
);

  // Controller strobes
  logic hdr_load;
  logic wr_en;
  logic rd_en;
  logic reply_start;
  logic reply_done;

  // Decoded header
  logic                 for_me;
  na_cmd_e              cmd;
  logic [TILE_W-1:0]    src;
  logic [REG_IDX_W-1:0] reg_idx;

  // Read value for the reply
  logic [FLIT_W-1:0] rd_data;

  na_ctrl u_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .in_flit_i    (in_flit_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .for_me_i     (for_me),
    .cmd_i        (cmd),
    .reply_done_i (reply_done),
    .hdr_load_o   (hdr_load),
    .wr_en_o      (wr_en),
    .rd_en_o      (rd_en),
    .reply_start_o(reply_start)
  );

  // Header word is read through the union field view
  na_hdr_decode #(
    .TILE_ID(TILE_ID)
  ) u_hdr_decode (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .hdr_load_i(hdr_load),
    .hdr_i     (noc_flit_u'(in_flit_i.data)),
    .for_me_o  (for_me),
    .cmd_o     (cmd),
    .src_o     (src),
    .reg_idx_o (reg_idx)
  );

  // Write data taken straight off the input link
  na_regfile #(
    .NUM_REGS(NUM_REGS)
  ) u_regfile (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wr_en_i  (wr_en),
    .rd_en_i  (rd_en),
    .reg_idx_i(reg_idx),
    .wr_data_i(in_flit_i.data),
    .rd_data_o(rd_data),
    .trace_o  (trace_o)
  );

  na_reply_gen #(
    .TILE_ID(TILE_ID)
  ) u_reply_gen (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .reply_start_i(reply_start),
    .src_i        (src),
    .reg_idx_i    (reg_idx),
    .rd_data_i    (rd_data),
    .out_ready_i  (out_ready_i),
    .out_flit_o   (out_flit_o),
    .out_valid_o  (out_valid_o),
    .reply_done_o (reply_done)
  );

endmodule

// File: design/na_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Network adapter controller
// Owns the input handshake and sequences decode, register access,
// reply and drop of each incoming packet
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module na_ctrl import mpsoc_tile_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  // Input port, only the last marker is needed here
  input  noc_flit_t in_flit_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // From header decoder
  input  logic      for_me_i,
  input  na_cmd_e   cmd_i,
  // From reply generator
  input  logic      reply_done_i,
  // Datapath strobes
  output logic      hdr_load_o,
  output logic      wr_en_o,
  output logic      rd_en_o,
  output logic      reply_start_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DECODE,
    ST_PAYLOAD,
    ST_TRACE,
    ST_REPLY,
    ST_DROP
  } state_e;

  state_e state_q;
  state_e state_d;

  // Last marker of the most recently accepted flit
  logic last_q;
  logic in_fire;

  assign in_fire = in_valid_i && in_ready_o;

  //////////////////////////////////////////////////////////////////////
  // State and last-flit register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (in_fire) begin
        last_q <= in_flit_i.last;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    in_ready_o    = 1'b0;
    hdr_load_o    = 1'b0;
    wr_en_o       = 1'b0;
    rd_en_o       = 1'b0;
    reply_start_o = 1'b0;

    case (state_q)
      ST_IDLE: begin
        // Wait for a header, hand it to the decoder
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          hdr_load_o = 1'b1;
          state_d    = ST_DECODE;
        end
      end

      ST_DECODE: begin
        // Decoded fields are valid here, input held off
        if (for_me_i && cmd_i == CMD_WRITE && !last_q) begin
          state_d = ST_PAYLOAD;
        end else if (for_me_i && cmd_i == CMD_READ) begin
          // Latch read data and launch reply header together
          rd_en_o       = 1'b1;
          reply_start_o = 1'b1;
          state_d       = ST_REPLY;
        end else if (last_q) begin
          // Header-only packet not for us, done already
          state_d = ST_IDLE;
        end else begin
          state_d = ST_DROP;
        end
      end

      ST_PAYLOAD: begin
        // Payload goes straight into the register bank
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          wr_en_o = 1'b1;
          state_d = ST_TRACE;
        end
      end

      ST_TRACE: begin
        // Trace record is out this cycle
        state_d = last_q ? ST_IDLE : ST_DROP;
      end

      ST_REPLY: begin
        // Hold input until reply data flit is gone
        if (reply_done_i) begin
          state_d = last_q ? ST_IDLE : ST_DROP;
        end
      end

      ST_DROP: begin
        // Swallow flits up to and including the last one
        in_ready_o = 1'b1;
        if (in_valid_i && in_flit_i.last) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

endmodule

// File: design/na_hdr_decode.sv
//////////////////////////////////////////////////////////////////////
// Header decoder
// Captures an accepted header and reports whether this tile serves it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module na_hdr_decode import mpsoc_tile_pkg::*; #(
  parameter logic [TILE_W-1:0] TILE_ID = '0
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 hdr_load_i,
  input  noc_flit_u            hdr_i,
  output logic                 for_me_o,
  output na_cmd_e              cmd_o,
  output logic [TILE_W-1:0]    src_o,
  output logic [REG_IDX_W-1:0] reg_idx_o
);

  logic serviceable;

  // Only write and read are handled locally
  assign serviceable = (hdr_i.hdr.cmd == CMD_WRITE) || (hdr_i.hdr.cmd == CMD_READ);

  // Control outputs, cleared on reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for_me_o <= 1'b0;
      cmd_o    <= CMD_RSVD;
    end else if (hdr_load_i) begin
      for_me_o <= (hdr_i.hdr.dest == TILE_ID) && serviceable;
      cmd_o    <= hdr_i.hdr.cmd;
    end
  end

  // Addressing fields, only meaningful after a load
  always_ff @(posedge clk) begin
    if (hdr_load_i) begin
      src_o     <= hdr_i.hdr.src;
      reg_idx_o <= hdr_i.hdr.reg_idx;
    end
  end

endmodule

// File: design/na_regfile.sv
//////////////////////////////////////////////////////////////////////
// Local register bank
// One write port, one latched read port, writeback trace output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module na_regfile import mpsoc_tile_pkg::*; #(
  parameter int unsigned NUM_REGS = 16
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 wr_en_i,
  input  logic                 rd_en_i,
  input  logic [REG_IDX_W-1:0] reg_idx_i,
  input  logic [FLIT_W-1:0]    wr_data_i,
  output logic [FLIT_W-1:0]    rd_data_o,
  output trace_t               trace_o
);

  logic [FLIT_W-1:0] regs_q [NUM_REGS];

  logic                 idx_ok;
  logic                 trace_vld_q;
  logic [REG_IDX_W-1:0] trace_reg_q;
  logic [FLIT_W-1:0]    trace_data_q;

  // Indices past the bank are ignored
  assign idx_ok = (reg_idx_i < NUM_REGS);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && idx_ok) begin
      regs_q[reg_idx_i] <= wr_data_i;
    end
  end

  // Read value held for the reply data flit
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= idx_ok ? regs_q[reg_idx_i] : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback trace
  //////////////////////////////////////////////////////////////////////

  // One-cycle pulse per stored write
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_vld_q <= 1'b0;
    end else begin
      trace_vld_q <= wr_en_i && idx_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      trace_reg_q  <= reg_idx_i;
      trace_data_q <= wr_data_i;
    end
  end

  assign trace_o = '{valid: trace_vld_q, wbreg: trace_reg_q, wbdata: trace_data_q};

endmodule

// File: design/na_reply_gen.sv
//////////////////////////////////////////////////////////////////////
// Reply generator
// Sends a two-flit reply packet and holds each flit under back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module na_reply_gen import mpsoc_tile_pkg::*; #(
  parameter logic [TILE_W-1:0] TILE_ID = '0
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 reply_start_i,
  input  logic [TILE_W-1:0]    src_i,
  input  logic [REG_IDX_W-1:0] reg_idx_i,
  input  logic [FLIT_W-1:0]    rd_data_i,
  input  logic                 out_ready_i,
  output noc_flit_t            out_flit_o,
  output logic                 out_valid_o,
  output logic                 reply_done_o
);

  typedef enum logic [1:0] {
    RP_IDLE,
    RP_HDR,
    RP_DATA
  } rp_state_e;

  rp_state_e state_q;
  noc_flit_u reply_hdr;

  // Reply header, addressed back to the requester
  always_comb begin
    reply_hdr.raw           = '0;
    reply_hdr.hdr.dest      = src_i;
    reply_hdr.hdr.pkt_class = PKT_CLASS_MP;
    reply_hdr.hdr.src       = TILE_ID;
    reply_hdr.hdr.cmd       = CMD_REPLY;
    reply_hdr.hdr.reg_idx   = reg_idx_i;
  end

  // Packet complete when the data flit leaves
  assign reply_done_o = (state_q == RP_DATA) && out_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Sequencing and valid
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= RP_IDLE;
      out_valid_o <= 1'b0;
    end else begin
      case (state_q)
        RP_IDLE: begin
          if (reply_start_i) begin
            state_q     <= RP_HDR;
            out_valid_o <= 1'b1;
          end
        end
        RP_HDR: begin
          // Data flit follows right after the header goes
          if (out_ready_i) begin
            state_q <= RP_DATA;
          end
        end
        RP_DATA: begin
          if (out_ready_i) begin
            state_q     <= RP_IDLE;
            out_valid_o <= 1'b0;
          end
        end
        default: begin
          state_q     <= RP_IDLE;
          out_valid_o <= 1'b0;
        end
      endcase
    end
  end

  // Flit register, changes only on a start or a transfer
  always_ff @(posedge clk) begin
    if (state_q == RP_IDLE && reply_start_i) begin
      out_flit_o <= '{data: reply_hdr.raw, last: 1'b0};
    end else if (state_q == RP_HDR && out_ready_i) begin
      out_flit_o <= '{data: rd_data_i, last: 1'b1};
    end
  end

endmodule

// File: mpsoc_tile.f
design/mpsoc_tile_pkg.sv
design/na_ctrl.sv
design/na_hdr_decode.sv
design/na_regfile.sv
design/na_reply_gen.sv
design/mpsoc_tile_top.sv
testbench/mpsoc_tile_assertions.sv
testbench/mpsoc_tile_tb.sv

// File: testbench/mpsoc_tile_assertions.sv
//////////////////////////////////////////////////////////////////////
// Tile endpoint assertions
// Output hold under back-pressure, trace pulse width, input hold-off
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mpsoc_tile_assertions import mpsoc_tile_pkg::*; (
  input logic      clk,
  input logic      rst_n_i,
  input logic      in_ready_i,
  input noc_flit_t out_flit_i,
  input logic      out_valid_i,
  input logic      out_ready_i,
  input trace_t    trace_i
);

  int unsigned fail_count = 0;

  // Stalled flit stays put with valid held
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
    else begin
      fail_count++;
      $error("Output flit dropped or changed while stalled");
    end

  // Trace is a single-cycle pulse
  a_trace_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    trace_i.valid |=> !trace_i.valid)
    else begin
      fail_count++;
      $error("Trace valid held for two cycles");
    end

  // No input accepted while a reply is on the link
  a_in_hold_off: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i |-> !in_ready_i)
    else begin
      fail_count++;
      $error("Input ready while a reply flit is valid");
    end

endmodule

bind mpsoc_tile_top mpsoc_tile_assertions i_assertions (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .in_ready_i (in_ready_o),
  .out_flit_i (out_flit_o),
  .out_valid_i(out_valid_o),
  .out_ready_i(out_ready_i),
  .trace_i    (trace_o)
);

// File: testbench/mpsoc_tile_tb.sv
//////////////////////////////////////////////////////////////////////
// Tile endpoint testbench
// Applies a packet table to one tile and checks replies and traces
// against a reference register model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mpsoc_tile_tb import mpsoc_tile_pkg::*; ();

  localparam logic [4:0] TILE_ID     = 5'd3;
  localparam int         NUM_PKTS    = 30;
  localparam int         CYCLE_LIMIT = NUM_PKTS * 40 + 16;

  // Expected outcome of one packet
  typedef enum logic [1:0] {K_WRITE, K_REPLY, K_DROP} kind_e;

  typedef struct packed {
    logic [31:0] hdr;
    logic [31:0] payload;
    logic        has_payload;
    kind_e       kind;
  } pkt_t;

  logic      clk;
  logic      rst_n_i;
  noc_flit_t in_flit_i;
  logic      in_valid_i;
  logic      in_ready_o;
  noc_flit_t out_flit_o;
  logic      out_valid_o;
  logic      out_ready_i;
  trace_t    trace_o;

  pkt_t        table_q [NUM_PKTS];
  logic [31:0] ref_regs [16];
  noc_flit_t   exp_out [$];
  int          errors;
  int          writes;
  int          trace_pulses;
  int          reply_flits;
  int          cycle_count;

  mpsoc_tile_top #(
    .TILE_ID (TILE_ID),
    .NUM_REGS(16)
  ) i_dut (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_flit_i  (in_flit_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .out_flit_o (out_flit_o),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .trace_o    (trace_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAILED %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic count_failure(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  // Header word laid out as dest, class, src, cmd, reg_idx, reserved
  function automatic logic [31:0] make_hdr(input logic [4:0] dest, input logic [4:0] src,
                                           input na_cmd_e cmd, input logic [3:0] idx);
    noc_hdr_t h;
    h = '{dest: dest, pkt_class: 3'd0, src: src, cmd: cmd, reg_idx: idx, rsvd: '0};
    return h;
  endfunction

  // Present one flit from a falling edge until it is accepted
  task automatic send_flit(input logic [31:0] data, input logic last);
    logic ready;
    in_flit_i  = '{data: data, last: last};
    in_valid_i = 1'b1;
    ready      = 1'b0;
    while (!ready) begin
      // in_ready_o only moves on a rising edge
      ready = in_ready_o;
      @(negedge clk);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic build_table();
    // Every register reads zero after reset
    for (int i = 0; i < 16; i++) begin
      table_q[i] = '{make_hdr(TILE_ID, 5'(10 + i), CMD_READ, 4'(i)), '0, 1'b0, K_REPLY};
    end
    table_q[16] = '{make_hdr(TILE_ID, 5'd7, CMD_WRITE, 4'd2), 32'hCAFE_0002, 1'b1, K_WRITE};
    table_q[17] = '{make_hdr(TILE_ID, 5'd1, CMD_WRITE, 4'd9), 32'h1234_5678, 1'b1, K_WRITE};
    table_q[18] = '{make_hdr(TILE_ID, 5'd7, CMD_READ, 4'd2), '0, 1'b0, K_REPLY};
    // Other tile, reserved and reply commands, stray write header
    table_q[19] = '{make_hdr(5'd5, 5'd7, CMD_WRITE, 4'd2), 32'hDEAD_BEEF, 1'b1, K_DROP};
    table_q[20] = '{make_hdr(TILE_ID, 5'd7, CMD_RSVD, 4'd9), 32'h0BAD_0BAD, 1'b1, K_DROP};
    table_q[21] = '{make_hdr(TILE_ID, 5'd2, CMD_REPLY, 4'd2), '0, 1'b0, K_DROP};
    table_q[22] = '{make_hdr(TILE_ID, 5'd2, CMD_WRITE, 4'd9), '0, 1'b0, K_DROP};
    table_q[23] = '{make_hdr(TILE_ID, 5'd12, CMD_READ, 4'd2), '0, 1'b0, K_REPLY};
    table_q[24] = '{make_hdr(TILE_ID, 5'd0, CMD_READ, 4'd9), '0, 1'b0, K_REPLY};
    table_q[25] = '{make_hdr(TILE_ID, 5'd4, CMD_WRITE, 4'd2), 32'hA5A5_0001, 1'b1, K_WRITE};
    table_q[26] = '{make_hdr(TILE_ID, 5'd4, CMD_WRITE, 4'd15), 32'hFFFF_0000, 1'b1, K_WRITE};
    table_q[27] = '{make_hdr(5'd4, 5'd9, CMD_READ, 4'd15), '0, 1'b0, K_DROP};
    table_q[28] = '{make_hdr(TILE_ID, 5'd31, CMD_READ, 4'd15), '0, 1'b0, K_REPLY};
    table_q[29] = '{make_hdr(TILE_ID, 5'd30, CMD_READ, 4'd2), '0, 1'b0, K_REPLY};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output port, random back-pressure and reply checks
  //////////////////////////////////////////////////////////////////////

  initial begin
    noc_flit_t pend_flit;
    noc_flit_t exp;
    logic      pend;
    void'($urandom(95169));
    out_ready_i = 1'b0;
    pend        = 1'b0;
    forever begin
      @(negedge clk);
      // Flit seen ready and valid last cycle went out on the rising edge
      if (pend) begin
        reply_flits++;
        if (exp_out.size() == 0) begin
          count_failure("output flit sent with no reply pending");
        end else begin
          exp = exp_out.pop_front();
          if (pend_flit.data !== exp.data) begin
            report_mismatch("out_flit_o.data", pend_flit.data, exp.data);
          end
          if (pend_flit.last !== exp.last) begin
            report_mismatch("out_flit_o.last", pend_flit.last, exp.last);
          end
        end
      end
      // About 70 percent ready
      out_ready_i = ($urandom_range(99) < 70);
      pend        = out_valid_o && out_ready_i;
      pend_flit   = out_flit_o;
    end
  end

  // Trace pulses, one sample per cycle
  always @(negedge clk) begin
    if (trace_o.valid === 1'b1) begin
      trace_pulses++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d", errors);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    pkt_t      pkt;
    noc_hdr_t  h;
    noc_flit_t exp_flit;
    int        assert_fails;
    errors       = 0;
    writes       = 0;
    trace_pulses = 0;
    reply_flits  = 0;
    cycle_count  = 0;
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_flit_i    = '0;
    for (int i = 0; i < 16; i++) begin
      ref_regs[i] = '0;
    end
    build_table();
    repeat (16) @(negedge clk);
    rst_n_i = 1'b1;

    if (in_ready_o !== 1'b1) report_mismatch("in_ready_o", in_ready_o, 1'b1);
    if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", out_valid_o, 1'b0);
    if (trace_o.valid !== 1'b0) report_mismatch("trace_o.valid", trace_o.valid, 1'b0);

    for (int n = 0; n < NUM_PKTS; n++) begin
      pkt = table_q[n];
      h   = noc_hdr_t'(pkt.hdr);
      // Reply header goes back to the sender with this tile as source
      if (pkt.kind == K_REPLY) begin
        exp_flit = '{data: make_hdr(h.src, TILE_ID, CMD_REPLY, h.reg_idx), last: 1'b0};
        exp_out.push_back(exp_flit);
        exp_flit = '{data: ref_regs[h.reg_idx], last: 1'b1};
        exp_out.push_back(exp_flit);
      end
      send_flit(pkt.hdr, !pkt.has_payload);
      // Decode cycle, input held off and no reply on the link yet
      if (in_ready_o !== 1'b0) report_mismatch("in_ready_o", in_ready_o, 1'b0);
      if (out_valid_o !== 1'b0) report_mismatch("out_valid_o", out_valid_o, 1'b0);
      if (pkt.kind == K_REPLY) begin
        @(negedge clk);
        if (out_valid_o !== 1'b1) report_mismatch("out_valid_o", out_valid_o, 1'b1);
      end
      if (pkt.has_payload) begin
        send_flit(pkt.payload, 1'b1);
        if (pkt.kind == K_WRITE) begin
          // Trace record in the cycle after the payload
          if (trace_o.valid !== 1'b1) begin
            report_mismatch("trace_o.valid", trace_o.valid, 1'b1);
          end
          if (trace_o.wbreg !== h.reg_idx) begin
            report_mismatch("trace_o.wbreg", trace_o.wbreg, h.reg_idx);
          end
          if (trace_o.wbdata !== pkt.payload) begin
            report_mismatch("trace_o.wbdata", trace_o.wbdata, pkt.payload);
          end
          if (in_ready_o !== 1'b0) report_mismatch("in_ready_o", in_ready_o, 1'b0);
          ref_regs[h.reg_idx] = pkt.payload;
          writes++;
        end
      end
    end

    // Let the last reply drain
    while (exp_out.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    if (trace_pulses != writes) count_failure("trace pulse count differs from write count");

    assert_fails = i_dut.i_assertions.fail_count;
    $display("Packets %0d, reply flits %0d, trace pulses %0d, assertion failures %0d, errors %0d",
             NUM_PKTS, reply_flits, trace_pulses, assert_fails, errors);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
